// File: design/spart_driver_cfg.svh
// Configuration constants for the serial-port host driver
`ifndef SPART_DRIVER_CFG_SVH
`define SPART_DRIVER_CFG_SVH

// memory and cpu widths
`define SPD_MEM_AW 14
`define SPD_WORD_W 64
`define SPD_PC_W 16

// command slot at the top of data memory
`define SPD_LAST_SLOT 14'h3fff
// highest pc value of the boot loop
`define SPD_BOOT_PC 16'd3

// receive-side baud divisors, one per selection
`define SPD_BAUD_0 16'h0082
`define SPD_BAUD_1 16'h028b
`define SPD_BAUD_2 16'h0146
`define SPD_BAUD_3 16'h00a3

// character encodings
`define SPD_CH_ZERO 8'h30
`define SPD_CH_SEND 8'h73
`define SPD_CH_START 8'h61
`define SPD_CH_END 8'h65
`define SPD_FRAME_LEN 9

`endif

// File: design/spart_driver_pkg.sv
// Shared types for the serial-port host driver
`include "spart_driver_cfg.svh"

package spart_driver_pkg;

   // serial data byte
   typedef logic [7:0] byte_t;

   // memory port
   typedef logic [`SPD_MEM_AW-1:0] mem_addr_t;
   typedef logic [`SPD_WORD_W-1:0] mem_word_t;

   // program counter from the cpu fetch stage
   typedef logic [`SPD_PC_W-1:0] pc_t;

   // divisor written to the port in two halves
   typedef logic [15:0] baud_t;

   // port register select
   typedef logic [1:0] ioaddr_t;

   // decoded command character
   typedef enum logic [1:0]
   {
      CMD_NONE,
      CMD_SEND,
      CMD_START,
      CMD_END
   } cmd_e;

   // main controller states
   typedef enum logic [2:0]
   {
      CTRL_BAUD_LOW,
      CTRL_BAUD_HIGH,
      CTRL_IDLE,
      CTRL_ECHO,
      CTRL_WAIT_RUN,
      CTRL_RUN,
      CTRL_WAIT_FLUSH,
      CTRL_SEND
   } ctrl_state_e;

   // result sender states
   typedef enum logic [1:0]
   {
      SEND_IDLE,
      SEND_READ,
      SEND_LOAD,
      SEND_BYTES
   } send_state_e;

endpackage

// File: design/frame_decoder.sv
// Frame decoder that stores the eight digits, decodes the command and keeps the window
`include "spart_driver_cfg.svh"

module frame_decoder
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load_i,
   input  spart_driver_pkg::byte_t       rx_byte_i,
   input  logic                          cmd_ack_i,
   output spart_driver_pkg::cmd_e        cmd_o,
   output spart_driver_pkg::mem_word_t   word_o,
   output spart_driver_pkg::mem_addr_t   win_start_o,
   output spart_driver_pkg::mem_addr_t   win_end_o
);
   import spart_driver_pkg::*;

   localparam int DIGITS = `SPD_FRAME_LEN - 1;

   logic [3:0] pos_q;
   logic       last_pos;
   byte_t      digit_q [0:DIGITS-1];
   cmd_e       cmd_q;
   cmd_e       cmd_dec;
   mem_addr_t  start_q;
   mem_addr_t  end_q;

   //////////////////////////////////////////////////////////////////////
   // character position within the frame
   //////////////////////////////////////////////////////////////////////

   // the ninth character is the command
   assign last_pos = (pos_q == 4'(DIGITS));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pos_q <= 4'd0;
      else if (load_i)
      begin
         if (last_pos)
            pos_q <= 4'd0;
         else
            pos_q <= pos_q + 4'd1;
      end
   end

   // digits are kept as values, not ascii
   always_ff @(posedge clk)
   begin
      if (load_i && !last_pos)
         digit_q[pos_q[2:0]] <= rx_byte_i - byte_t'(`SPD_CH_ZERO);
   end

   // position 0 lands in the top byte
   always_comb
   begin
      for (int i = 0; i < DIGITS; i++)
         word_o[`SPD_WORD_W-1-8*i -: 8] = digit_q[i];
   end

   //////////////////////////////////////////////////////////////////////
   // command decode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      case (rx_byte_i)
         `SPD_CH_SEND:  cmd_dec = CMD_SEND;
         `SPD_CH_START: cmd_dec = CMD_START;
         `SPD_CH_END:   cmd_dec = CMD_END;
         default:       cmd_dec = CMD_NONE;
      endcase
   end

   // held until the controller acknowledges it
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         cmd_q <= CMD_NONE;
      else if (load_i && last_pos)
         cmd_q <= cmd_dec;
      else if (cmd_ack_i)
         cmd_q <= CMD_NONE;
   end

   assign cmd_o = cmd_q;

   //////////////////////////////////////////////////////////////////////
   // result window
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_q <= '0;
         end_q   <= '0;
      end
      else if (cmd_ack_i)
      begin
         // only the low address bits of the packed word matter
         if (cmd_q == CMD_START)
            start_q <= word_o[`SPD_MEM_AW-1:0];
         if (cmd_q == CMD_END)
            end_q <= word_o[`SPD_MEM_AW-1:0];
      end
   end

   assign win_start_o = start_q;
   assign win_end_o   = end_q;

endmodule

// File: design/run_controller.sv
// Main controller that owns the serial port and memory port and sequences each run
`include "spart_driver_cfg.svh"

module run_controller
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [1:0]                    br_cfg_i,
   input  logic                          rda_i,
   input  logic                          tbr_i,
   input  spart_driver_pkg::byte_t       dbus_i,
   input  spart_driver_pkg::pc_t         cpu_pc_i,
   input  logic                          mem_fin_i,
   input  spart_driver_pkg::cmd_e        cmd_i,
   input  spart_driver_pkg::mem_word_t   word_i,
   input  logic                          rd_en_i,
   input  spart_driver_pkg::mem_addr_t   rd_addr_i,
   input  logic                          tx_valid_i,
   input  spart_driver_pkg::byte_t       tx_byte_i,
   input  logic                          done_i,
   output spart_driver_pkg::ioaddr_t     ioaddr_o,
   output logic                          iorw_o,
   output spart_driver_pkg::byte_t       dbus_o,
   output logic                          enb_o,
   output logic                          web_o,
   output spart_driver_pkg::mem_addr_t   addrb_o,
   output spart_driver_pkg::mem_word_t   dinb_o,
   output logic                          flsh_o,
   output logic                          load_o,
   output spart_driver_pkg::byte_t       rx_byte_o,
   output logic                          cmd_ack_o,
   output logic                          start_o,
   output logic                          send_ok_o
);
   import spart_driver_pkg::*;

   // port register map
   localparam ioaddr_t REG_DATA   = 2'd0;
   localparam ioaddr_t REG_STATUS = 2'd1;
   localparam ioaddr_t REG_DIV_LO = 2'd2;
   localparam ioaddr_t REG_DIV_HI = 2'd3;

   ctrl_state_e state_q;
   ctrl_state_e state_d;
   logic [1:0]  cfg_q;
   logic        cfg_upd;
   logic        fin_q;
   byte_t       echo_q;
   baud_t       divisor;

   //////////////////////////////////////////////////////////////////////
   // state, baud selection and flush-done latch
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= CTRL_BAUD_LOW;
         cfg_q   <= 2'd0;
         fin_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (cfg_upd)
            cfg_q <= br_cfg_i;
         // a new flush cancels the old finish
         if (flsh_o)
            fin_q <= 1'b0;
         else if (mem_fin_i)
            fin_q <= 1'b1;
      end
   end

   // received character kept for the echo
   always_ff @(posedge clk)
   begin
      if (load_o)
         echo_q <= dbus_i;
   end

   always_comb
   begin
      case (br_cfg_i)
         2'd0:    divisor = `SPD_BAUD_0;
         2'd1:    divisor = `SPD_BAUD_1;
         2'd2:    divisor = `SPD_BAUD_2;
         default: divisor = `SPD_BAUD_3;
      endcase
   end

   assign rx_byte_o = dbus_i;
   // per-word go for the sender
   assign send_ok_o = tbr_i && fin_q && (state_q == CTRL_SEND);

   //////////////////////////////////////////////////////////////////////
   // next state and bus control
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // idle bus reads the status register
      state_d   = state_q;
      ioaddr_o  = REG_STATUS;
      iorw_o    = 1'b1;
      dbus_o    = '0;
      enb_o     = 1'b0;
      web_o     = 1'b0;
      addrb_o   = `SPD_LAST_SLOT;
      dinb_o    = word_i;
      flsh_o    = 1'b0;
      load_o    = 1'b0;
      cmd_ack_o = 1'b0;
      start_o   = 1'b0;
      cfg_upd   = 1'b0;
      case (state_q)
         CTRL_BAUD_LOW:
         begin
            ioaddr_o = REG_DIV_LO;
            iorw_o   = 1'b0;
            dbus_o   = divisor[7:0];
            state_d  = CTRL_BAUD_HIGH;
         end
         CTRL_BAUD_HIGH:
         begin
            ioaddr_o = REG_DIV_HI;
            iorw_o   = 1'b0;
            dbus_o   = divisor[15:8];
            cfg_upd  = 1'b1;
            state_d  = CTRL_IDLE;
         end
         CTRL_IDLE:
         begin
            if (br_cfg_i != cfg_q)
               state_d = CTRL_BAUD_LOW;
            else if (cmd_i != CMD_NONE)
            begin
               cmd_ack_o = 1'b1;
               // window commands are taken by the decoder
               if (cmd_i == CMD_SEND)
               begin
                  enb_o   = 1'b1;
                  web_o   = 1'b1;
                  state_d = CTRL_WAIT_RUN;
               end
            end
            else if (rda_i)
            begin
               ioaddr_o = REG_DATA;
               load_o   = 1'b1;
               state_d  = CTRL_ECHO;
            end
         end
         CTRL_ECHO:
         begin
            if (tbr_i)
            begin
               ioaddr_o = REG_DATA;
               iorw_o   = 1'b0;
               dbus_o   = echo_q;
               state_d  = CTRL_IDLE;
            end
         end
         CTRL_WAIT_RUN:
         begin
            // cpu has left the boot loop, so run the benchmark only once
            if (cpu_pc_i > `SPD_BOOT_PC)
            begin
               enb_o   = 1'b1;
               web_o   = 1'b1;
               dinb_o  = '0;
               state_d = CTRL_RUN;
            end
         end
         CTRL_RUN:
         begin
            if (cpu_pc_i <= `SPD_BOOT_PC)
            begin
               flsh_o  = 1'b1;
               start_o = 1'b1;
               state_d = CTRL_WAIT_FLUSH;
            end
         end
         CTRL_WAIT_FLUSH:
         begin
            if (fin_q)
               state_d = CTRL_SEND;
         end
         CTRL_SEND:
         begin
            // sender owns both ports here
            enb_o   = rd_en_i;
            addrb_o = rd_addr_i;
            if (tx_valid_i)
            begin
               ioaddr_o = REG_DATA;
               iorw_o   = 1'b0;
               dbus_o   = tx_byte_i;
            end
            if (done_i)
               state_d = CTRL_IDLE;
         end
         default:
            state_d = CTRL_IDLE;
      endcase
   end

endmodule

// File: design/result_sender.sv
// Result sender that reads the memory window and serializes each word high byte first
`include "spart_driver_cfg.svh"

module result_sender
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          start_i,
   input  logic                          send_ok_i,
   input  logic                          tbr_i,
   input  spart_driver_pkg::mem_addr_t   win_start_i,
   input  spart_driver_pkg::mem_addr_t   win_end_i,
   input  spart_driver_pkg::mem_word_t   doutb_i,
   output logic                          rd_en_o,
   output spart_driver_pkg::mem_addr_t   rd_addr_o,
   output logic                          tx_valid_o,
   output spart_driver_pkg::byte_t       tx_byte_o,
   output logic                          done_o
);
   import spart_driver_pkg::*;

   send_state_e state_q;
   mem_addr_t   addr_q;
   logic        more_q;
   logic [2:0]  byte_cnt_q;
   mem_word_t   buf_q;

   //////////////////////////////////////////////////////////////////////
   // word and byte sequencing
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= SEND_IDLE;
         addr_q     <= '0;
         more_q     <= 1'b0;
         byte_cnt_q <= 3'd0;
      end
      else
      begin
         case (state_q)
            SEND_IDLE:
            begin
               if (start_i)
               begin
                  addr_q  <= win_start_i;
                  // empty window when start is above end
                  more_q  <= (win_start_i <= win_end_i);
                  state_q <= SEND_READ;
               end
            end
            SEND_READ:
            begin
               if (send_ok_i)
               begin
                  if (more_q)
                  begin
                     // flag tracks the end so the counter may wrap safely
                     more_q  <= (addr_q != win_end_i);
                     addr_q  <= addr_q + 1'b1;
                     state_q <= SEND_LOAD;
                  end
                  else
                     state_q <= SEND_IDLE;
               end
            end
            SEND_LOAD:
            begin
               byte_cnt_q <= 3'd0;
               state_q    <= SEND_BYTES;
            end
            SEND_BYTES:
            begin
               if (tbr_i)
               begin
                  byte_cnt_q <= byte_cnt_q + 3'd1;
                  if (byte_cnt_q == 3'd7)
                     state_q <= SEND_READ;
               end
            end
            default:
               state_q <= SEND_IDLE;
         endcase
      end
   end

   // read data arrives one cycle after the request
   always_ff @(posedge clk)
   begin
      if (state_q == SEND_LOAD)
         buf_q <= doutb_i;
      else if (state_q == SEND_BYTES && tbr_i)
         buf_q <= buf_q << 8;
   end

   assign rd_en_o    = (state_q == SEND_READ) && send_ok_i && more_q;
   assign rd_addr_o  = addr_q;
   assign tx_valid_o = (state_q == SEND_BYTES) && tbr_i;
   assign tx_byte_o  = buf_q[`SPD_WORD_W-1 -: 8];
   assign done_o     = (state_q == SEND_READ) && send_ok_i && !more_q;

endmodule

// File: design/spart_driver.sv
// Top level of the serial-port host driver that loads benchmarks and returns results
module spart_driver
(
   input  logic                          clk,
   input  logic                          rst_n,
   // serial port
   input  logic [1:0]                    br_cfg_i,
   input  logic                          rda_i,
   input  logic                          tbr_i,
   input  spart_driver_pkg::byte_t       dbus_i,
   output spart_driver_pkg::ioaddr_t     ioaddr_o,
   output logic                          iorw_o,
   output spart_driver_pkg::byte_t       dbus_o,
   // data memory port b
   output logic                          enb_o,
   output logic                          web_o,
   output spart_driver_pkg::mem_addr_t   addrb_o,
   output spart_driver_pkg::mem_word_t   dinb_o,
   input  spart_driver_pkg::mem_word_t   doutb_i,
   // cpu and memory system
   input  spart_driver_pkg::pc_t         cpu_pc_i,
   output logic                          flsh_o,
   input  logic                          mem_fin_i
);
   import spart_driver_pkg::*;

   // decoder to controller
   logic      load;
   byte_t     rx_byte;
   logic      cmd_ack;
   cmd_e      cmd;
   mem_word_t word;
   mem_addr_t win_start;
   mem_addr_t win_end;

   // sender to controller
   logic      start;
   logic      send_ok;
   logic      rd_en;
   mem_addr_t rd_addr;
   logic      tx_valid;
   byte_t     tx_byte;
   logic      done;

   frame_decoder u_frame_decoder
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_i      (load),
      .rx_byte_i   (rx_byte),
      .cmd_ack_i   (cmd_ack),
      .cmd_o       (cmd),
      .word_o      (word),
      .win_start_o (win_start),
      .win_end_o   (win_end)
   );

   run_controller u_run_controller
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .br_cfg_i   (br_cfg_i),
      .rda_i      (rda_i),
      .tbr_i      (tbr_i),
      .dbus_i     (dbus_i),
      .cpu_pc_i   (cpu_pc_i),
      .mem_fin_i  (mem_fin_i),
      .cmd_i      (cmd),
      .word_i     (word),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .tx_valid_i (tx_valid),
      .tx_byte_i  (tx_byte),
      .done_i     (done),
      .ioaddr_o   (ioaddr_o),
      .iorw_o     (iorw_o),
      .dbus_o     (dbus_o),
      .enb_o      (enb_o),
      .web_o      (web_o),
      .addrb_o    (addrb_o),
      .dinb_o     (dinb_o),
      .flsh_o     (flsh_o),
      .load_o     (load),
      .rx_byte_o  (rx_byte),
      .cmd_ack_o  (cmd_ack),
      .start_o    (start),
      .send_ok_o  (send_ok)
   );

   result_sender u_result_sender
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_i     (start),
      .send_ok_i   (send_ok),
      .tbr_i       (tbr_i),
      .win_start_i (win_start),
      .win_end_i   (win_end),
      .doutb_i     (doutb_i),
      .rd_en_o     (rd_en),
      .rd_addr_o   (rd_addr),
      .tx_valid_o  (tx_valid),
      .tx_byte_o   (tx_byte),
      .done_o      (done)
   );

endmodule

// File: test/spart_driver_sva.sv
// Bound protocol checks on the serial-port bus, the flush pulse and the memory port
module spart_driver_sva
(
   input logic                       clk,
   input logic                       rst_n,
   input spart_driver_pkg::ioaddr_t  ioaddr_i,
   input logic                       iorw_i,
   input logic                       flsh_i,
   input logic                       enb_i,
   input logic                       web_i
);

   // a write goes to the data register or one of the divisor halves
   port_write_chk: assert property (@(posedge clk) disable iff (!rst_n)
      !iorw_i |-> (ioaddr_i != 2'd1))
      else $error("port write to the status register");

   // flush request is a single-cycle strobe
   flush_pulse_chk: assert property (@(posedge clk) disable iff (!rst_n)
      flsh_i |=> !flsh_i)
      else $error("flush request held for more than one cycle");

   // write enable only together with the port enable
   mem_write_chk: assert property (@(posedge clk) disable iff (!rst_n)
      web_i |-> enb_i)
      else $error("memory write enable without port enable");

endmodule

// File: test/spart_driver_tb.sv
// Testbench for the serial-port host driver with stimulus and expectations from a pattern file
module spart_driver_tb;
   import spart_driver_pkg::*;

   localparam int SEED         = 75968;
   localparam int PAT_MAX      = 128;
   localparam int QUIET_CYCLES = 24;

   logic       clk;
   logic       rst_n;
   logic [1:0] br_cfg_i;
   logic       rda_i;
   logic       tbr_i;
   byte_t      dbus_i;
   ioaddr_t    ioaddr_o;
   logic       iorw_o;
   byte_t      dbus_o;
   logic       enb_o;
   logic       web_o;
   mem_addr_t  addrb_o;
   mem_word_t  dinb_o;
   mem_word_t  doutb_i;
   pc_t        cpu_pc_i;
   logic       flsh_o;
   logic       mem_fin_i;

   // pattern records and the 16K-word memory model
   logic [31:0] pat [0:PAT_MAX-1];
   mem_word_t   mem [0:16383];

   // observed traffic filled by the monitor
   byte_t       tx_q [$];
   logic [8:0]  baud_q [$];
   logic [77:0] wr_q [$];
   int          rd_taken    = 0;
   int          flush_cnt   = 0;
   logic        rd_pend     = 1'b0;
   mem_addr_t   rd_addr;
   int          cycle_cnt   = 0;
   int          cycle_limit = 100000;

   initial clk = 1'b0;
   always #4 clk = ~clk;

   spart_driver dut0
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .br_cfg_i  (br_cfg_i),
      .rda_i     (rda_i),
      .tbr_i     (tbr_i),
      .dbus_i    (dbus_i),
      .ioaddr_o  (ioaddr_o),
      .iorw_o    (iorw_o),
      .dbus_o    (dbus_o),
      .enb_o     (enb_o),
      .web_o     (web_o),
      .addrb_o   (addrb_o),
      .dinb_o    (dinb_o),
      .doutb_i   (doutb_i),
      .cpu_pc_i  (cpu_pc_i),
      .flsh_o    (flsh_o),
      .mem_fin_i (mem_fin_i)
   );

   bind spart_driver spart_driver_sva sva0
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .ioaddr_i (ioaddr_o),
      .iorw_i   (iorw_o),
      .flsh_i   (flsh_o),
      .enb_i    (enb_o),
      .web_i    (web_o)
   );

   //////////////////////////////////////////////////////////////////////
   // error reporting and helpers
   //////////////////////////////////////////////////////////////////////

   task automatic stop_run();
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_run();
   endtask

   task automatic report_error(input string msg);
      $display("ERROR time=%0t %s", $time, msg);
      stop_run();
   endtask

   // memory fill where every address bit shows up in the word
   function automatic mem_word_t fill_word(input mem_addr_t a);
      return {10'h2a7, a, 2'b10, ~a, 2'b01, a ^ 14'h2d4b, 8'hc3};
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   //////////////////////////////////////////////////////////////////////
   // port, memory and timeout models
   //////////////////////////////////////////////////////////////////////

   // outputs are stable midway between the falling and the rising edge
   always @(negedge clk)
   begin
      #2;
      if (rst_n)
      begin
         if (!iorw_o && ioaddr_o == 2'd0)
            tx_q.push_back(dbus_o);
         if (!iorw_o && ioaddr_o[1])
            baud_q.push_back({ioaddr_o[0], dbus_o});
         if (iorw_o && ioaddr_o == 2'd0)
         begin
            // a data read only takes a byte that the port has ready
            assert (rda_i)
               else report_error("data register read while no received byte was ready");
            rd_taken++;
         end
         if (enb_o && web_o)
         begin
            wr_q.push_back({addrb_o, dinb_o});
            mem[addrb_o] = dinb_o;
         end
         if (flsh_o)
            flush_cnt++;
         rd_pend = enb_o && !web_o;
         rd_addr = addrb_o;
      end
   end

   // random transmit-empty level and read data one cycle after the request
   initial
   begin
      void'($urandom(SEED));
      tbr_i   = 1'b1;
      doutb_i = '0;
      forever
      begin
         @(negedge clk);
         tbr_i = ($urandom % 4) != 0;
         if (rd_pend)
            doutb_i = mem[rd_addr];
      end
   end

   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit)
         report_error("timeout, the DUT did not finish the pattern sequence");
   end

   //////////////////////////////////////////////////////////////////////
   // checking tasks
   //////////////////////////////////////////////////////////////////////

   // low half to register 2, then high half to register 3
   task automatic check_baud(input baud_t div);
      logic [8:0] lo;
      logic [8:0] hi;
      while (baud_q.size() < 2)
         @(negedge clk);
      lo = baud_q.pop_front();
      hi = baud_q.pop_front();
      assert (lo == {1'b0, div[7:0]})
         else report_mismatch("ioaddr_o/dbus_o divisor low", 64'(lo), 64'({1'b0, div[7:0]}));
      assert (hi == {1'b1, div[15:8]})
         else report_mismatch("ioaddr_o/dbus_o divisor high", 64'(hi), 64'({1'b1, div[15:8]}));
   endtask

   // offer one byte, wait until it is taken, then expect its echo
   task automatic send_char(input byte_t ch);
      int    taken;
      byte_t echo;
      taken = rd_taken;
      @(negedge clk);
      dbus_i = ch;
      rda_i  = 1'b1;
      while (rd_taken == taken)
         @(negedge clk);
      rda_i = 1'b0;
      while (tx_q.size() == 0)
         @(negedge clk);
      echo = tx_q.pop_front();
      assert (echo == ch)
         else report_mismatch("dbus_o echo", 64'(echo), 64'(ch));
   endtask

   task automatic check_quiet();
      wait_cycles(QUIET_CYCLES);
      assert (wr_q.size() == 0)
         else report_error("memory write after a frame without the send command");
      assert (tx_q.size() == 0)
         else report_error("serial bytes after a frame without the send command");
      assert (flush_cnt == 0)
         else report_error("flush request outside a run");
   endtask

   // slot write, cpu handshake, flush, then the window high byte first
   task automatic run_and_check(input mem_word_t word, input mem_addr_t w_start,
                                input mem_addr_t w_end);
      logic [77:0] wr;
      mem_word_t   exp_word;
      byte_t       exp_byte;
      byte_t       got;
      int          a;
      while (wr_q.size() == 0)
         @(negedge clk);
      wr = wr_q.pop_front();
      assert (wr[77:64] == 14'h3fff)
         else report_mismatch("addrb_o slot write", 64'(wr[77:64]), 64'h3fff);
      assert (wr[63:0] == word)
         else report_mismatch("dinb_o slot write", wr[63:0], word);
      // slot stays until the cpu leaves the boot loop
      wait_cycles(3);
      assert (wr_q.size() == 0)
         else report_error("slot cleared while the cpu was still in the boot loop");
      cpu_pc_i = 16'h0100;
      while (wr_q.size() == 0)
         @(negedge clk);
      wr = wr_q.pop_front();
      assert (wr[77:64] == 14'h3fff)
         else report_mismatch("addrb_o slot clear", 64'(wr[77:64]), 64'h3fff);
      assert (wr[63:0] == '0)
         else report_mismatch("dinb_o slot clear", wr[63:0], 64'd0);
      wait_cycles(3);
      assert (flush_cnt == 0)
         else report_error("flush request before the cpu returned to the boot loop");
      // benchmark done and cpu back in the boot loop
      cpu_pc_i = 16'd2;
      while (flush_cnt == 0)
         @(negedge clk);
      wait_cycles(2);
      mem_fin_i = 1'b1;
      @(negedge clk);
      mem_fin_i = 1'b0;
      if (w_start <= w_end)
      begin
         for (a = int'(w_start); a <= int'(w_end); a++)
         begin
            exp_word = (a == 16383) ? '0 : fill_word(mem_addr_t'(a));
            for (int b = 7; b >= 0; b--)
            begin
               exp_byte = exp_word[8*b +: 8];
               while (tx_q.size() == 0)
                  @(negedge clk);
               got = tx_q.pop_front();
               assert (got == exp_byte)
                  else report_mismatch("dbus_o result byte", 64'(got), 64'(exp_byte));
            end
         end
      end
      wait_cycles(QUIET_CYCLES);
      assert (tx_q.size() == 0)
         else report_error("more result bytes than the window holds");
      assert (wr_q.size() == 0)
         else report_error("memory write during the result phase");
      assert (flush_cnt == 1)
         else report_mismatch("flsh_o pulse count", 64'(flush_cnt), 64'd1);
      flush_cnt = 0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      int          idx;
      int          pos;
      int          n_chars;
      int          n_bytes;
      logic [31:0] ent;
      mem_word_t   packed_word;

      rst_n     = 1'b0;
      br_cfg_i  = 2'd0;
      rda_i     = 1'b0;
      dbus_i    = '0;
      cpu_pc_i  = 16'd2;
      mem_fin_i = 1'b0;
      for (int a = 0; a < 16384; a++)
         mem[a] = fill_word(mem_addr_t'(a));
      for (int i = 0; i < PAT_MAX; i++)
         pat[i] = 32'hf0000000;
      $readmemh("test/spart_driver_patterns.txt", pat);

      // limit grows with the characters and result bytes in the patterns
      n_chars = 0;
      n_bytes = 0;
      for (idx = 0; idx < PAT_MAX && pat[idx][31:28] != 4'hf; idx++)
      begin
         if (pat[idx][31:28] == 4'h2)
            n_chars++;
         if (pat[idx][31:28] == 4'h3 && pat[idx][27:14] <= pat[idx][13:0])
            n_bytes += 8 * (int'(pat[idx][13:0]) - int'(pat[idx][27:14]) + 1);
      end
      cycle_limit = 400 + 64 * n_chars + 16 * n_bytes;

      if (pat[0][31:28] == 4'h1)
         br_cfg_i = pat[0][17:16];
      repeat (8) @(negedge clk);
      rst_n = 1'b1;

      idx         = 0;
      pos         = 0;
      packed_word = '0;
      while (idx < PAT_MAX && pat[idx][31:28] != 4'hf)
      begin
         ent = pat[idx];
         case (ent[31:28])
            4'h1:
            begin
               @(negedge clk);
               br_cfg_i = ent[17:16];
               check_baud(ent[15:0]);
            end
            4'h2:
            begin
               // digits become values with position 0 in the top byte
               if (pos < 8)
                  packed_word = {packed_word[55:0], ent[7:0] - 8'h30};
               send_char(ent[7:0]);
               pos++;
               if (pos == 9)
               begin
                  pos = 0;
                  if (ent[7:0] != 8'h73)
                     check_quiet();
               end
            end
            4'h3:
               run_and_check(packed_word, ent[27:14], ent[13:0]);
            default:
               report_error("unknown record kind in the pattern file");
         endcase
         idx++;
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

// File: spart_driver.f
+incdir+design
design/spart_driver_pkg.sv
design/frame_decoder.sv
design/run_controller.sv
design/result_sender.sv
design/spart_driver.sv
test/spart_driver_sva.sv
test/spart_driver_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module spart_driver_tb -f spart_driver.f -o spart_driver_sim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/spart_driver_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

echo "simulation finished cleanly"
exit 0

// File: test/spart_driver_patterns.txt
// kind in the top digit: 1 baud {sel[17:16], divisor[15:0]}, 2 received char [7:0],
// 3 run {window start[27:14], window end[13:0]}, f end; one frame of nine chars per line
10020146
// window start 0x0102, then window end 0x0104
20000030 20000030 20000030 20000030 20000030 20000030 20000031 20000032 20000061
20000030 20000030 20000030 20000030 20000030 20000030 20000031 20000034 20000065
// send the packed word 0x0102030405060708, result read from 0x0102 to 0x0104
20000031 20000032 20000033 20000034 20000035 20000036 20000037 20000038 20000073
30408104
// new baud selection
1001028b
// unknown command character
20000039 20000038 20000037 20000036 20000035 20000034 20000033 20000032 20000078
// start 0x0200 above end 0x0104, so the run sends nothing
20000030 20000030 20000030 20000030 20000030 20000030 20000032 20000030 20000061
20000038 20000037 20000036 20000035 20000034 20000033 20000032 20000031 20000073
30800104
100300a3
f0000000
